// File: Bender.yml
package:
  name: player_camera

sources:
  - raycastPkg.sv
  - mapRom.sv
  - cameraRotator.sv
  - playerController.sv
  - playerTop.sv
  - target: simulation
    files:
      - playerTb.sv

// File: cameraRotator.sv
module cameraRotator (
  input  logic                pixel_clk_in,
  input  logic                rst_in,
  input  logic                rotStart,  // one-cycle request
  input  logic                rotLeft,   // held alongside rotStart
  input  raycastPkg::camera_t cameraIn,
  output logic                rotDone,   // follows rotStart by one cycle
  output raycastPkg::vec2_t   rotDir,
  output raycastPkg::vec2_t   rotPlane
);

  // products of dir with the rotation terms
  logic signed [31:0] dxCos, dyCos, dxSin, dySin;
  // same for the plane vector
  logic signed [31:0] pxCos, pyCos, pxSin, pySin;

  raycastPkg::vec2_t dirNext, planeNext;

  // add two products, round half up and drop the fraction
  function automatic raycastPkg::fixed_t roundSum(input logic signed [31:0] a,
                                                  input logic signed [31:0] b);
    logic signed [31:0] s;
    s = a + b + (32'sd1 <<< (raycastPkg::FRAC_BITS - 1));
    return raycastPkg::fixed_t'(s >>> raycastPkg::FRAC_BITS); // keep low 16 bits
  endfunction

  always_comb begin
    // full 16x16 signed multiplies
    dxCos = cameraIn.dir.x * raycastPkg::COS_ROT;
    dyCos = cameraIn.dir.y * raycastPkg::COS_ROT;
    dxSin = cameraIn.dir.x * raycastPkg::SIN_ROT;
    dySin = cameraIn.dir.y * raycastPkg::SIN_ROT;
    pxCos = cameraIn.plane.x * raycastPkg::COS_ROT;
    pyCos = cameraIn.plane.y * raycastPkg::COS_ROT;
    pxSin = cameraIn.plane.x * raycastPkg::SIN_ROT;
    pySin = cameraIn.plane.y * raycastPkg::SIN_ROT;

    if (rotLeft) begin
      // x' = x cos + y sin, y' = -x sin + y cos
      dirNext.x   = roundSum(dxCos, dySin);
      dirNext.y   = roundSum(-dxSin, dyCos);
      planeNext.x = roundSum(pxCos, pySin);
      planeNext.y = roundSum(-pxSin, pyCos);
    end else begin
      // right turn just flips the sin terms
      dirNext.x   = roundSum(dxCos, -dySin);
      dirNext.y   = roundSum(dxSin, dyCos);
      planeNext.x = roundSum(pxCos, -pySin);
      planeNext.y = roundSum(pxSin, pyCos);
    end
  end

  // vectors are payload, registered every cycle
  always_ff @(posedge pixel_clk_in) begin
    rotDir   <= dirNext;
    rotPlane <= planeNext;
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      rotDone <= 1'b0;
    end else begin
      rotDone <= rotStart; // one stage, new start allowed each cycle
    end
  end

  // done pulse lines up with the start of the previous cycle
  doneFollowsStart: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    rotDone == $past(rotStart));

endmodule

// File: compile.f
raycastPkg.sv
mapRom.sv
cameraRotator.sv
playerController.sv
playerTop.sv
playerTb.sv

// File: map.mem
// 24x24 tiles, one line per row from row 0, columns 0 to 23 left to right
// 00 is open floor, any other value is a wall
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 02 02 00 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 03 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01

// File: mapRom.sv
module mapRom #(
  parameter int MAP_SIZE = 24,
  localparam int ADDR_W = $clog2(MAP_SIZE * MAP_SIZE)
) (
  input  logic              pixel_clk_in,
  input  logic              rst_in,
  input  logic [ADDR_W-1:0] mapAddr,  // row * MAP_SIZE + column
  output raycastPkg::tile_t tileData  // valid two edges after mapAddr
);

  // tile array, read only, filled once at load time
  raycastPkg::tile_t mem [MAP_SIZE * MAP_SIZE];

  logic [ADDR_W-1:0] addrReg; // first stage, address capture

  initial begin
    $readmemh("map.mem", mem);
  end

  always_ff @(posedge pixel_clk_in) begin
    addrReg <= mapAddr;
  end

  // second stage is the output register, like a high-performance bram
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      tileData <= '0; // output cleared, contents kept
    end else begin
      tileData <= mem[addrReg];
    end
  end

endmodule

// File: playerController.sv
module playerController #(
  parameter int MAP_SIZE = 24,
  localparam int ADDR_W = $clog2(MAP_SIZE * MAP_SIZE)
) (
  input  logic                pixel_clk_in,
  input  logic                rst_in,
  input  logic [1:0]          moveDir,     // fwd, back
  input  logic [1:0]          rotDir,      // left, right
  input  logic                rotDone,
  input  raycastPkg::vec2_t   rotDirIn,
  input  raycastPkg::vec2_t   rotPlaneIn,
  input  raycastPkg::tile_t   tileData,
  output logic                rotStart,
  output logic                rotLeft,
  output logic [ADDR_W-1:0]   mapAddr,
  output raycastPkg::camera_t camera,
  output logic                busy
);

  typedef enum logic [2:0] {
    stIdle,
    stFetch,   // rom latching the address
    stWait,    // rom output register loading
    stDecide,  // tile valid, commit or drop the move
    stRotate   // waiting on the rotator
  } state_t;

  state_t state;

  // candidate move, computed from the live camera
  logic signed [31:0] mulX, mulY;
  raycastPkg::fixed_t stepX, stepY;
  raycastPkg::vec2_t  candNext;
  logic [15:0]        rndX, rndY;
  logic [7:0]         colIdx, rowIdx;
  logic               inRangeNext;
  logic [ADDR_W-1:0]  addrNext;

  // registered candidate, held through the rom read
  raycastPkg::vec2_t candPos;
  logic              candOk;

  logic cmdMove, cmdRot;

  assign cmdMove = state == stIdle && moveDir != 2'b00;
  assign cmdRot  = state == stIdle && moveDir == 2'b00 && rotDir != 2'b00;
  assign busy    = state != stIdle; // rises at the sample edge, falls at commit

  always_comb begin
    mulX  = camera.dir.x * raycastPkg::MOVE_STEP;
    mulY  = camera.dir.y * raycastPkg::MOVE_STEP;
    // same half-lsb rounding as the rotator
    stepX = raycastPkg::fixed_t'((mulX + (32'sd1 <<< (raycastPkg::FRAC_BITS - 1)))
                                 >>> raycastPkg::FRAC_BITS);
    stepY = raycastPkg::fixed_t'((mulY + (32'sd1 <<< (raycastPkg::FRAC_BITS - 1)))
                                 >>> raycastPkg::FRAC_BITS);

    if (moveDir[1]) begin // forward wins over back
      candNext.x = camera.pos.x + stepX;
      candNext.y = camera.pos.y + stepY;
    end else begin
      candNext.x = camera.pos.x - stepX;
      candNext.y = camera.pos.y - stepY;
    end

    // nearest tile, add half then keep the integer byte
    rndX   = candNext.x + 16'h0080;
    rndY   = candNext.y + 16'h0080;
    colIdx = 8'(rndX >> raycastPkg::FRAC_BITS);
    rowIdx = 8'(rndY >> raycastPkg::FRAC_BITS);

    inRangeNext = !candNext.x[15] && !candNext.y[15] &&
                  colIdx < MAP_SIZE && rowIdx < MAP_SIZE;
    // out of range still reads the rom, tile 0 is as good as any
    addrNext = inRangeNext ? ADDR_W'(rowIdx * MAP_SIZE + colIdx) : '0;
  end

  always_ff @(posedge pixel_clk_in) begin
    if (cmdMove) begin
      candPos <= candNext;
      candOk  <= inRangeNext;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state          <= stIdle;
      rotStart       <= 1'b0;
      rotLeft        <= 1'b0;
      mapAddr        <= '0;
      camera.pos.x   <= 16'sh0C80; // 12.5
      camera.pos.y   <= 16'sh0C80;
      camera.dir.x   <= 16'sh0000;
      camera.dir.y   <= 16'sh0100; // facing +y
      camera.plane.x <= 16'sh00A9; // 0.66
      camera.plane.y <= 16'sh0000;
    end else begin
      rotStart <= 1'b0; // single-cycle pulse
      case (state)
        stIdle: begin
          if (cmdMove) begin
            mapAddr <= addrNext;
            state   <= stFetch;
          end else if (cmdRot) begin
            rotStart <= 1'b1;
            rotLeft  <= rotDir[1]; // left beats right
            state    <= stRotate;
          end
        end
        stFetch:  state <= stWait;
        stWait:   state <= stDecide;
        stDecide: begin
          if (candOk && tileData == '0) camera.pos <= candPos; // empty floor only
          state <= stIdle;
        end
        stRotate: begin
          if (rotDone) begin
            camera.dir   <= rotDirIn;
            camera.plane <= rotPlaneIn;
            state        <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  idleAfterReset: assert property (@(posedge pixel_clk_in) rst_in |=> !busy);

  // position only moves on the decide edge
  posOnlyInDecide: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    state != stDecide |=> $stable(camera.pos));

  doneOnlyInRotate: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    rotDone |-> state == stRotate);

endmodule

// File: playerTb.sv
module playerTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAP_SIZE     = 24;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 300;
  // a command needs at most 5 cycles here, so the directed part fits in the slack
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_RANDOM * 8;

  // pos (12.5, 12.5), dir (0, 1.0), plane (0.66, 0)
  localparam raycastPkg::camera_t RESET_CAM = {16'h0C80, 16'h0C80, 16'h0000, 16'h0100,
                                               16'h00A9, 16'h0000};

  logic                pixel_clk_in;
  logic                rst_in;
  logic [1:0]          moveDir;  // fwd, back
  logic [1:0]          rotDir;   // left, right
  raycastPkg::camera_t camera;
  logic                busy;

  raycastPkg::tile_t   tiles [MAP_SIZE * MAP_SIZE]; // own copy of the map
  raycastPkg::camera_t model;          // state after all commands sent so far
  raycastPkg::camera_t refCam;         // what camera has to show right now
  raycastPkg::camera_t expQ[$];
  int                  latQ[$];
  logic [31:0]         rngState;
  int                  cycleCount = 0;
  int                  blockedCount;   // moves the model refused
  logic                inCmd;
  int                  edgeIdx, curLat;

  playerTop #(.MAP_SIZE(MAP_SIZE)) DUT (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .moveDir      (moveDir),
    .rotDir       (rotDir),
    .camera       (camera),
    .busy         (busy)
  );

  initial begin
    pixel_clk_in = 1'b0;
    forever #4 pixel_clk_in = ~pixel_clk_in; // 8 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // product sum back to 8.8: add half an lsb, floor shift, wrap to 16 bits
  function automatic raycastPkg::fixed_t fixRound(input longint p);
    longint r;
    r = (p + (longint'(1) <<< (raycastPkg::FRAC_BITS - 1))) >>> raycastPkg::FRAC_BITS;
    return raycastPkg::fixed_t'(r[15:0]);
  endfunction

  function automatic raycastPkg::vec2_t turnVec(input raycastPkg::vec2_t v, input logic left);
    longint xc, ys, xs, yc;
    raycastPkg::vec2_t r;
    xc = longint'(v.x) * raycastPkg::COS_ROT;
    ys = longint'(v.y) * raycastPkg::SIN_ROT;
    xs = longint'(v.x) * raycastPkg::SIN_ROT;
    yc = longint'(v.y) * raycastPkg::COS_ROT;
    if (left) begin
      r.x = fixRound(xc + ys);
      r.y = fixRound(yc - xs); // -x sin + y cos
    end else begin
      r.x = fixRound(xc - ys);
      r.y = fixRound(yc + xs);
    end
    return r;
  endfunction

  // next camera for one sampled command, priority fwd, back, left, right
  function automatic raycastPkg::camera_t refNext(input raycastPkg::camera_t cam,
                                                  input logic [1:0] move,
                                                  input logic [1:0] rot);
    raycastPkg::camera_t nxt;
    raycastPkg::vec2_t   step, cand;
    logic [15:0]         cx, cy;
    int                  col, row;
    nxt = cam;
    step.x = fixRound(longint'(cam.dir.x) * raycastPkg::MOVE_STEP);
    step.y = fixRound(longint'(cam.dir.y) * raycastPkg::MOVE_STEP);
    if (move != 2'b00) begin
      cand.x = move[1] ? cam.pos.x + step.x : cam.pos.x - step.x;
      cand.y = move[1] ? cam.pos.y + step.y : cam.pos.y - step.y;
      cx  = cand.x + 16'h0080;
      cy  = cand.y + 16'h0080;
      col = cx[15:8]; // integer byte after rounding
      row = cy[15:8];
      if (!cand.x[15] && !cand.y[15] && col < MAP_SIZE && row < MAP_SIZE) begin
        if (tiles[row * MAP_SIZE + col] == 8'h00) nxt.pos = cand;
      end
    end else if (rot != 2'b00) begin
      nxt.dir   = turnVec(cam.dir, rot[1]);
      nxt.plane = turnVec(cam.plane, rot[1]);
    end
    return nxt;
  endfunction

  function automatic int cmdLatency(input logic [1:0] move, input logic [1:0] rot);
    if (move != 2'b00) return 3; // fetch, wait, decide
    if (rot != 2'b00) return 2;  // rotator stage, then commit
    return 0;
  endfunction

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkCamera(input raycastPkg::camera_t got, input raycastPkg::camera_t exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] camera got %h expected %h", got, exp));
    end
  endtask

  task automatic checkBusy(input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("[FAIL] busy got %h expected %h", got, exp));
    end
  endtask

  // drive one command, optionally scramble inputs while busy, return once busy is low
  task automatic sendCmd(input logic [1:0] move, input logic [1:0] rot, input logic noisy);
    raycastPkg::camera_t nxt;
    int                  lat;
    @(negedge pixel_clk_in);
    moveDir = move;
    rotDir  = rot;
    lat = cmdLatency(move, rot);
    if (lat != 0) begin
      nxt = refNext(model, move, rot);
      if (move != 2'b00 && nxt.pos == model.pos) blockedCount++;
      model = nxt;
      latQ.push_back(lat);
      expQ.push_back(nxt);
      @(negedge pixel_clk_in); // edge 0 has sampled it
      checkBusy(busy, 1'b1);
      while (busy) begin
        if (noisy) begin
          rngState = xorshift(rngState);
          moveDir  = rngState[1:0];
          rotDir   = rngState[3:2];
        end
        @(negedge pixel_clk_in);
      end
      moveDir = 2'b00;
      rotDir  = 2'b00;
    end
  endtask

  // compare process, every falling edge: busy window length and camera value
  always @(negedge pixel_clk_in) begin
    if (rst_in) begin
      inCmd  = 1'b0;
      refCam = RESET_CAM;
    end else begin
      if (!inCmd && busy) begin
        if (latQ.size() == 0) begin
          stopOnError("busy rose without any command being sent");
        end else begin
          inCmd   = 1'b1;
          edgeIdx = 0;
          curLat  = latQ.pop_front();
        end
      end
      if (inCmd) begin
        checkBusy(busy, edgeIdx < curLat); // falls exactly at the commit edge
        if (edgeIdx == curLat) begin
          refCam = expQ.pop_front();
          inCmd  = 1'b0;
        end
        edgeIdx++;
      end
      checkCamera(camera, refCam); // also catches changes outside a commit
    end
  end

  always @(posedge pixel_clk_in) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      stopOnError("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    logic [1:0] mv, rt;
    moveDir      = 2'b00;
    rotDir       = 2'b00;
    rst_in       = 1'b1;
    rngState     = 32'h225c;
    blockedCount = 0;
    model        = RESET_CAM;
    $readmemh("map.mem", tiles);
    repeat (RESET_CYCLES) @(negedge pixel_clk_in);
    rst_in = 1'b0;
    @(negedge pixel_clk_in);
    checkCamera(camera, RESET_CAM);
    checkBusy(busy, 1'b0);

    repeat (4) sendCmd(2'b00, 2'b10, 1'b0); // turn left
    repeat (4) sendCmd(2'b00, 2'b01, 1'b0); // and back right
    repeat (2) sendCmd(2'b10, 2'b00, 1'b0);
    repeat (2) sendCmd(2'b01, 2'b00, 1'b0);
    if (blockedCount != 0) stopOnError("a move on open floor was blocked by the model");

    // straight toward the +y border
    repeat (14) sendCmd(2'b10, 2'b00, 1'b0);
    if (blockedCount == 0) stopOnError("the forward run never reached the wall");

    sendCmd(2'b11, 2'b11, 1'b1); // forward wins, noise while busy
    sendCmd(2'b01, 2'b11, 1'b1);
    sendCmd(2'b00, 2'b11, 1'b1); // left beats right

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rngState = xorshift(rngState);
      case (rngState[2:0])
        3'd0, 3'd1: mv = 2'b10;
        3'd2:       mv = 2'b11;
        3'd3:       mv = 2'b01;
        default:    mv = 2'b00;
      endcase
      rt = rngState[5:4]; // only acts with no move bit set
      sendCmd(mv, rt, rngState[8]);
    end

    repeat (4) @(negedge pixel_clk_in);
    if (latQ.size() != 0 || expQ.size() != 0) begin
      stopOnError("some commands were never completed by the DUT");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: playerTop.sv
module playerTop #(
  parameter int MAP_SIZE = 24
) (
  input  logic                pixel_clk_in,
  input  logic                rst_in,
  input  logic [1:0]          moveDir,  // fwd, back
  input  logic [1:0]          rotDir,   // left, right
  output raycastPkg::camera_t camera,
  output logic                busy
);

  localparam int ADDR_W = $clog2(MAP_SIZE * MAP_SIZE);

  logic                rotStart, rotLeft, rotDone;
  raycastPkg::vec2_t   rotDirVec, rotPlaneVec; // rotator results
  logic [ADDR_W-1:0]   mapAddr;
  raycastPkg::tile_t   tileData;

  playerController #(.MAP_SIZE(MAP_SIZE)) ctrl (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .moveDir      (moveDir),
    .rotDir       (rotDir),
    .rotDone      (rotDone),
    .rotDirIn     (rotDirVec),
    .rotPlaneIn   (rotPlaneVec),
    .tileData     (tileData),
    .rotStart     (rotStart),
    .rotLeft      (rotLeft),
    .mapAddr      (mapAddr),
    .camera       (camera),
    .busy         (busy)
  );

  cameraRotator rot (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .rotStart     (rotStart),
    .rotLeft      (rotLeft),
    .cameraIn     (camera),
    .rotDone      (rotDone),
    .rotDir       (rotDirVec),
    .rotPlane     (rotPlaneVec)
  );

  mapRom #(.MAP_SIZE(MAP_SIZE)) rom (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .mapAddr      (mapAddr),
    .tileData     (tileData)
  );

endmodule

// File: raycastPkg.sv
package raycastPkg;

  // number of fraction bits in every fixed-point word
  localparam int FRAC_BITS = 8;

  // signed 8.8, one integer byte and one fraction byte
  typedef logic signed [15:0] fixed_t;

  // 2d vector, x in the upper half
  typedef struct packed {
    fixed_t x;
    fixed_t y;
  } vec2_t;

  // full camera state as seen by the renderer
  typedef struct packed {
    vec2_t pos;   // exact location on the map
    vec2_t dir;   // facing direction, center of the view
    vec2_t plane; // camera plane, sets the fov width
  } camera_t;

  // one map cell; zero is open floor, anything else is a wall
  typedef logic [7:0] tile_t;

  // rotation matrix terms for a fixed 10 degree turn
  localparam fixed_t COS_ROT = 16'sh00FC; // cos(10) ~ 0.984, lands on 0.984375
  localparam fixed_t SIN_ROT = 16'sh002C; // sin(10) ~ 0.174, lands on 0.171875

  // distance covered by one move along dir
  localparam fixed_t MOVE_STEP = 16'sh0100; // exactly 1.0

endpackage
